//--- compile.f
+incdir+sim
src/rename_pkg.sv
src/rename_map_entry.sv
src/rename_map_table.sv
src/rename_free_list.sv
src/rename_unit.sv
sim/tb_rename_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f compile.f \
	--top-module tb_rename_unit -Mdir obj_dir

sim_out=$(./obj_dir/Vtb_rename_unit 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

//--- sim/tb_rename_checks.svh
`ifndef TB_RENAME_CHECKS_SVH
`define TB_RENAME_CHECKS_SVH

// One cycle of stimulus and the answer the DUT must give
typedef struct packed {
	// Rename slots 0 and 1
	logic [1:0] valid;
	logic [1:0] dest_valid;
	lreg_t [1:0] dest;
	lreg_t [1:0] src_a;
	lreg_t [1:0] src_b;
	// Retirement candidates 0 to 3
	logic [3:0] commit_valid;
	lreg_t [3:0] commit_lreg;
	preg_t [3:0] commit_preg;
	preg_t [3:0] commit_old;
	logic restart;
	// Expected handshake and results
	logic exp_ready;
	logic [1:0] exp_valid;
	preg_t [1:0] exp_dest;
	preg_t [1:0] exp_old;
	preg_t [1:0] exp_src_a;
	preg_t [1:0] exp_src_b;
} row_t;

// Report and end the run
task automatic fail_run(input string why);
	error_count++;
	$display("%s", why);
	$display("tests failed");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_preg(input string name, input preg_t got, input preg_t exp);
	string line;
	if (got !== exp) begin
		line = $sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
		fail_run(line);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	string line;
	if (got !== exp) begin
		line = $sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
		fail_run(line);
	end
endtask

// Registered results of one row, payload only when valid
task automatic check_results(input row_t d);
	for (int s = 0; s < 2; s++) begin
		check_bit($sformatf("out%0d_valid", s), out_valid[s], d.exp_valid[s]);
		if (d.exp_valid[s]) begin
			// No destination means nothing allocated
			if (d.dest_valid[s]) begin
				check_preg($sformatf("out%0d_dest_preg", s), out_dest[s], d.exp_dest[s]);
				check_preg($sformatf("out%0d_old_preg", s), out_old[s], d.exp_old[s]);
			end
			check_preg($sformatf("out%0d_src_a_preg", s), out_src_a[s], d.exp_src_a[s]);
			check_preg($sformatf("out%0d_src_b_preg", s), out_src_b[s], d.exp_src_b[s]);
		end
	end
endtask

`endif

//--- sim/tb_rename_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rename_unit
	import rename_pkg::*;
();

	localparam int CLK_PERIOD = 8;

	logic iCLOCK = 1'b0;
	logic inRESET;
	// DUT inputs indexed by slot or candidate
	logic [1:0] valid;
	logic [1:0] dest_valid;
	lreg_t [1:0] dest;
	lreg_t [1:0] src_a;
	lreg_t [1:0] src_b;
	logic [3:0] commit_valid;
	lreg_t [3:0] commit_lreg;
	preg_t [3:0] commit_preg;
	preg_t [3:0] commit_old;
	logic restart;
	// DUT outputs
	wire rename_ready;
	wire [1:0] out_valid;
	wire preg_t [1:0] out_dest;
	wire preg_t [1:0] out_old;
	wire preg_t [1:0] out_src_a;
	wire preg_t [1:0] out_src_b;

	int error_count = 0;
	logic table_ready = 1'b0;

	`include "tb_rename_checks.svh"

	row_t rows[$];
	// Row under construction
	row_t next_row = '0;

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	rename_unit u_rename_unit (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.slot0_valid(valid[0]), .slot0_dest_valid(dest_valid[0]), .slot0_dest_lreg(dest[0]),
		.slot0_src_a_lreg(src_a[0]), .slot0_src_b_lreg(src_b[0]),
		.slot1_valid(valid[1]), .slot1_dest_valid(dest_valid[1]), .slot1_dest_lreg(dest[1]),
		.slot1_src_a_lreg(src_a[1]), .slot1_src_b_lreg(src_b[1]),
		.rename_ready(rename_ready),
		.commit0_valid(commit_valid[0]), .commit0_lreg(commit_lreg[0]),
		.commit0_preg(commit_preg[0]), .commit0_old_preg(commit_old[0]),
		.commit1_valid(commit_valid[1]), .commit1_lreg(commit_lreg[1]),
		.commit1_preg(commit_preg[1]), .commit1_old_preg(commit_old[1]),
		.commit2_valid(commit_valid[2]), .commit2_lreg(commit_lreg[2]),
		.commit2_preg(commit_preg[2]), .commit2_old_preg(commit_old[2]),
		.commit3_valid(commit_valid[3]), .commit3_lreg(commit_lreg[3]),
		.commit3_preg(commit_preg[3]), .commit3_old_preg(commit_old[3]),
		.restart(restart),
		.out0_valid(out_valid[0]), .out0_dest_preg(out_dest[0]), .out0_old_preg(out_old[0]),
		.out0_src_a_preg(out_src_a[0]), .out0_src_b_preg(out_src_b[0]),
		.out1_valid(out_valid[1]), .out1_dest_preg(out_dest[1]), .out1_old_preg(out_old[1]),
		.out1_src_a_preg(out_src_a[1]), .out1_src_b_preg(out_src_b[1])
	);

	// One rename slot with its expected results
	task automatic put_slot(input int s, input logic has_dest, input lreg_t dst,
			input lreg_t a, input lreg_t b, input preg_t e_dest, input preg_t e_old,
			input preg_t e_a, input preg_t e_b);
		next_row.valid[s] = 1'b1;
		next_row.dest_valid[s] = has_dest;
		next_row.dest[s] = dst;
		next_row.src_a[s] = a;
		next_row.src_b[s] = b;
		next_row.exp_dest[s] = e_dest;
		next_row.exp_old[s] = e_old;
		next_row.exp_src_a[s] = e_a;
		next_row.exp_src_b[s] = e_b;
	endtask

	task automatic put_commit(input int c, input lreg_t l, input preg_t p, input preg_t old);
		next_row.commit_valid[c] = 1'b1;
		next_row.commit_lreg[c] = l;
		next_row.commit_preg[c] = p;
		next_row.commit_old[c] = old;
	endtask

	// Results follow ready since acceptance is all or nothing
	task automatic push_row(input logic rdy);
		next_row.exp_ready = rdy;
		next_row.exp_valid = rdy ? next_row.valid : 2'b00;
		rows.push_back(next_row);
		next_row = '0;
	endtask

	task automatic build_table();
		// Identity boot and lowest-first allocation from 32
		put_slot(0, 1'b1, 1, 2, 3, 32, 1, 2, 3);
		put_slot(1, 1'b1, 4, 5, 6, 33, 4, 5, 6);
		push_row(1'b1);
		// Slot 1 source b reads slot 0's destination
		put_slot(0, 1'b1, 7, 1, 4, 34, 7, 32, 33);
		put_slot(1, 1'b1, 8, 1, 7, 35, 8, 32, 34);
		push_row(1'b1);
		// Both slots write lreg 9
		put_slot(0, 1'b1, 9, 0, 0, 36, 9, 0, 0);
		put_slot(1, 1'b1, 9, 9, 8, 37, 36, 36, 35);
		push_row(1'b1);
		// Slot 1 takes alloc0 when slot 0 has no destination
		put_slot(0, 1'b0, 0, 9, 7, 0, 0, 37, 34);
		put_slot(1, 1'b1, 10, 1, 2, 38, 10, 32, 2);
		push_row(1'b1);
		// Drain 39 to 62 so that only 63 is left
		for (int k = 0; k < 12; k++) begin
			put_slot(0, 1'b1, 11, 0, 0, preg_t'(39 + 2 * k),
				(k == 0) ? preg_t'(11) : preg_t'(37 + 2 * k), 0, 0);
			put_slot(1, 1'b1, 12, 0, 0, preg_t'(40 + 2 * k),
				(k == 0) ? preg_t'(12) : preg_t'(38 + 2 * k), 0, 0);
			push_row(1'b1);
		end
		// Held bundle until a commit frees preg 1
		for (int k = 0; k < 3; k++) begin
			put_slot(0, 1'b1, 13, 0, 0, 0, 0, 0, 0);
			put_slot(1, 1'b1, 14, 0, 0, 0, 0, 0, 0);
			if (k == 2) begin
				put_commit(0, 1, 32, 1);
			end
			push_row(1'b0);
		end
		put_slot(0, 1'b1, 13, 0, 0, 1, 13, 0, 0);
		put_slot(1, 1'b1, 14, 0, 0, 63, 14, 0, 0);
		push_row(1'b1);
		// Candidate 3 wins the two commits to lreg 9
		put_commit(0, 4, 33, 4);
		put_commit(1, 7, 34, 7);
		put_commit(2, 9, 36, 9);
		put_commit(3, 9, 37, 36);
		push_row(1'b1);
		// Speculative work to be thrown away
		put_slot(0, 1'b1, 2, 1, 9, 4, 2, 32, 37);
		put_slot(1, 1'b1, 3, 2, 13, 7, 3, 4, 1);
		push_row(1'b1);
		// Registers freed by candidates 2 and 3
		put_slot(0, 1'b1, 5, 2, 3, 9, 5, 4, 7);
		put_slot(1, 1'b1, 6, 5, 0, 36, 6, 9, 0);
		push_row(1'b1);
		next_row.restart = 1'b1;
		push_row(1'b0);
		// Rollback map restored with free set 1 4 7 9 35 36 38 and up
		put_slot(0, 1'b1, 2, 2, 9, 1, 2, 2, 37);
		put_slot(1, 1'b1, 13, 1, 4, 4, 13, 32, 33);
		push_row(1'b1);
		put_slot(0, 1'b1, 7, 7, 8, 7, 34, 34, 8);
		put_slot(1, 1'b1, 0, 13, 2, 9, 0, 4, 1);
		push_row(1'b1);
		push_row(1'b1);
	endtask

	task automatic drive_row(input row_t d);
		valid = d.valid;
		dest_valid = d.dest_valid;
		dest = d.dest;
		src_a = d.src_a;
		src_b = d.src_b;
		commit_valid = d.commit_valid;
		commit_lreg = d.commit_lreg;
		commit_preg = d.commit_preg;
		commit_old = d.commit_old;
		restart = d.restart;
	endtask

	initial begin
		inRESET = 1'b0;
		drive_row('0);
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		// Nothing accepted during the boot cycle
		#(CLK_PERIOD - 2);
		check_bit("rename_ready", rename_ready, 1'b0);
		check_bit("out0_valid", out_valid[0], 1'b0);
		check_bit("out1_valid", out_valid[1], 1'b0);
		@(posedge iCLOCK);
		#1;
		foreach (rows[i]) begin
			drive_row(rows[i]);
			// Ready settles on this cycle's inputs
			#(CLK_PERIOD - 2);
			check_bit("rename_ready", rename_ready, rows[i].exp_ready);
			@(posedge iCLOCK);
			#1;
			check_results(rows[i]);
		end
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Covers reset and every row with margin
	initial begin
		wait (table_ready);
		#((rows.size() + 50) * CLK_PERIOD);
		fail_run("timeout: the stimulus table did not finish in time");
	end

endmodule

`default_nettype wire

//--- src/rename_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rename_unit
	import rename_pkg::*;
#(
	parameter int unsigned INIT_FREE_BASE = 32
)(
	input wire iCLOCK,
	input wire inRESET,
	// Rename requests
	input wire slot0_valid,
	input wire slot0_dest_valid,
	input wire lreg_t slot0_dest_lreg,
	input wire lreg_t slot0_src_a_lreg,
	input wire lreg_t slot0_src_b_lreg,
	input wire slot1_valid,
	input wire slot1_dest_valid,
	input wire lreg_t slot1_dest_lreg,
	input wire lreg_t slot1_src_a_lreg,
	input wire lreg_t slot1_src_b_lreg,
	output logic rename_ready,
	// Commit candidates
	input wire commit0_valid,
	input wire lreg_t commit0_lreg,
	input wire preg_t commit0_preg,
	input wire preg_t commit0_old_preg,
	input wire commit1_valid,
	input wire lreg_t commit1_lreg,
	input wire preg_t commit1_preg,
	input wire preg_t commit1_old_preg,
	input wire commit2_valid,
	input wire lreg_t commit2_lreg,
	input wire preg_t commit2_preg,
	input wire preg_t commit2_old_preg,
	input wire commit3_valid,
	input wire lreg_t commit3_lreg,
	input wire preg_t commit3_preg,
	input wire preg_t commit3_old_preg,
	input wire restart,
	// Results, one cycle after acceptance
	output logic out0_valid,
	output preg_t out0_dest_preg,
	output preg_t out0_old_preg,
	output preg_t out0_src_a_preg,
	output preg_t out0_src_b_preg,
	output logic out1_valid,
	output preg_t out1_dest_preg,
	output preg_t out1_old_preg,
	output preg_t out1_src_a_preg,
	output preg_t out1_src_b_preg
);

	localparam int CNT_W = $clog2(NUM_PREG) + 1;
	localparam int NEED_W = $clog2(RENAME_WIDTH) + 1;

	logic init_done;
	logic need0;
	logic need1;
	logic [NEED_W-1:0] need_count;
	logic accept;
	logic lock;
	logic wr0_valid;
	logic wr1_valid;
	preg_t new0;
	preg_t new1;
	preg_t alloc0;
	preg_t alloc1;
	logic [CNT_W-1:0] free_count;
	preg_t s0_a, s0_b, s0_old;
	preg_t s1_a, s1_b, s1_old;
	preg_vec_t rollback_vec;

	// Registers this bundle needs
	assign need0 = slot0_valid & slot0_dest_valid;
	assign need1 = slot1_valid & slot1_dest_valid;
	assign need_count = NEED_W'(need0) + NEED_W'(need1);

	// Whole bundle or nothing
	assign rename_ready = init_done && !restart && (free_count >= CNT_W'(need_count));
	assign accept = (slot0_valid | slot1_valid) && rename_ready;
	assign lock = !accept;

	// alloc0 goes to the first slot with a destination
	assign new0 = alloc0;
	assign new1 = need0 ? alloc1 : alloc0;
	assign wr0_valid = accept & need0;
	assign wr1_valid = accept & need1;

	rename_map_table u_map_table (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .restart(restart),
		.commit0_valid(commit0_valid), .commit0_lreg(commit0_lreg), .commit0_preg(commit0_preg),
		.commit1_valid(commit1_valid), .commit1_lreg(commit1_lreg), .commit1_preg(commit1_preg),
		.commit2_valid(commit2_valid), .commit2_lreg(commit2_lreg), .commit2_preg(commit2_preg),
		.commit3_valid(commit3_valid), .commit3_lreg(commit3_lreg), .commit3_preg(commit3_preg),
		.lock(lock),
		.write0_valid(wr0_valid), .write0_lreg(slot0_dest_lreg), .write0_preg(new0),
		.write1_valid(wr1_valid), .write1_lreg(slot1_dest_lreg), .write1_preg(new1),
		.slot0_src_a_lreg(slot0_src_a_lreg), .slot0_src_b_lreg(slot0_src_b_lreg),
		.slot1_src_a_lreg(slot1_src_a_lreg), .slot1_src_b_lreg(slot1_src_b_lreg),
		.slot0_src_a(s0_a), .slot0_src_b(s0_b), .slot0_old(s0_old),
		.slot1_src_a(s1_a), .slot1_src_b(s1_b), .slot1_old(s1_old),
		.rollback_vec(rollback_vec)
	);

	rename_free_list #(
		.INIT_FREE_BASE(INIT_FREE_BASE)
	) u_free_list (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .restart(restart),
		.rollback_vec(rollback_vec),
		.alloc0_en(accept & (need0 | need1)), .alloc1_en(accept & need0 & need1),
		.release0_valid(commit0_valid), .release0_preg(commit0_old_preg),
		.release1_valid(commit1_valid), .release1_preg(commit1_old_preg),
		.release2_valid(commit2_valid), .release2_preg(commit2_old_preg),
		.release3_valid(commit3_valid), .release3_preg(commit3_old_preg),
		.alloc0(alloc0), .alloc1(alloc1), .free_count(free_count)
	);

	// Map and free list boot during the first cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			init_done <= 1'b0;
			out0_valid <= 1'b0;
			out1_valid <= 1'b0;
		end else begin
			init_done <= 1'b1;
			out0_valid <= accept & slot0_valid;
			out1_valid <= accept & slot1_valid;
		end
	end

	// Result payload, held between accepted bundles
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			out0_dest_preg <= new0;
			out0_old_preg <= s0_old;
			out0_src_a_preg <= s0_a;
			out0_src_b_preg <= s0_b;
			out1_dest_preg <= new1;
			out1_old_preg <= s1_old;
			out1_src_a_preg <= s1_a;
			out1_src_b_preg <= s1_b;
		end
	end

endmodule

`default_nettype wire

//--- src/rename_free_list.sv
`timescale 1ns/100ps
`default_nettype none

module rename_free_list
	import rename_pkg::*;
#(
	parameter int unsigned INIT_FREE_BASE = 32
)(
	input wire iCLOCK,
	input wire inRESET,
	input wire restart,
	// Registers still held by committed state
	input wire preg_vec_t rollback_vec,
	// Consume alloc0 and alloc1 at this edge
	input wire alloc0_en,
	input wire alloc1_en,
	// Old registers returned by commits
	input wire release0_valid,
	input wire preg_t release0_preg,
	input wire release1_valid,
	input wire preg_t release1_preg,
	input wire release2_valid,
	input wire preg_t release2_preg,
	input wire release3_valid,
	input wire preg_t release3_preg,
	output preg_t alloc0,
	output preg_t alloc1,
	output logic [$clog2(NUM_PREG):0] free_count
);

	localparam int CNT_W = $clog2(NUM_PREG) + 1;

	free_state_t state;
	// One bit per free register
	preg_vec_t free_vec;
	preg_vec_t boot_vec;
	// Free set with alloc0 taken out
	preg_vec_t rest_vec;
	preg_vec_t alloc_mask;
	preg_vec_t release_mask;
	logic [COMMIT_WIDTH-1:0] rel_valid;
	preg_t rel_preg [COMMIT_WIDTH];

	// Index of the lowest set bit, zero when none
	function automatic preg_t lowest_set(input preg_vec_t vec);
		preg_t idx;
		idx = '0;
		// Scan downward so the lowest hit is the last one kept
		for (int i = NUM_PREG - 1; i >= 0; i--) begin
			if (vec[i]) begin
				idx = preg_t'(i);
			end
		end
		return idx;
	endfunction

	assign rel_valid = {release3_valid, release2_valid, release1_valid, release0_valid};
	assign rel_preg[0] = release0_preg;
	assign rel_preg[1] = release1_preg;
	assign rel_preg[2] = release2_preg;
	assign rel_preg[3] = release3_preg;

	// Registers at and above the base start free
	always_comb begin
		for (int i = 0; i < NUM_PREG; i++) begin
			boot_vec[i] = (i >= INIT_FREE_BASE);
		end
	end

	// Two lowest free registers
	assign alloc0 = lowest_set(free_vec);
	assign rest_vec = free_vec & ~(preg_vec_t'(1) << alloc0);
	assign alloc1 = lowest_set(rest_vec);

	always_comb begin
		alloc_mask = '0;
		if (alloc0_en) begin
			alloc_mask = alloc_mask | (preg_vec_t'(1) << alloc0);
		end
		if (alloc1_en) begin
			alloc_mask = alloc_mask | (preg_vec_t'(1) << alloc1);
		end
	end

	always_comb begin
		release_mask = '0;
		for (int i = 0; i < COMMIT_WIDTH; i++) begin
			if (rel_valid[i]) begin
				release_mask = release_mask | (preg_vec_t'(1) << rel_preg[i]);
			end
		end
	end

	// Population count of the free set
	always_comb begin
		free_count = '0;
		for (int i = 0; i < NUM_PREG; i++) begin
			free_count = free_count + CNT_W'(free_vec[i]);
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= init;
			free_vec <= '0;
		end else begin
			case (state)
				init: begin
					free_vec <= boot_vec;
					state <= run;
				end
				default: begin
					// Rebuild: free is whatever no rollback point holds
					if (restart) begin
						free_vec <= ~rollback_vec;
					end else begin
						free_vec <= (free_vec & ~alloc_mask) | release_mask;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/rename_map_table.sv
`timescale 1ns/100ps
`default_nettype none

module rename_map_table
	import rename_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire restart,
	// Commit candidates into the rollback points
	input wire commit0_valid,
	input wire lreg_t commit0_lreg,
	input wire preg_t commit0_preg,
	input wire commit1_valid,
	input wire lreg_t commit1_lreg,
	input wire preg_t commit1_preg,
	input wire commit2_valid,
	input wire lreg_t commit2_lreg,
	input wire preg_t commit2_preg,
	input wire commit3_valid,
	input wire lreg_t commit3_lreg,
	input wire preg_t commit3_preg,
	input wire lock,
	// Rename writes, the lreg doubles as the destination lookup
	input wire write0_valid,
	input wire lreg_t write0_lreg,
	input wire preg_t write0_preg,
	input wire write1_valid,
	input wire lreg_t write1_lreg,
	input wire preg_t write1_preg,
	// Source lookups
	input wire lreg_t slot0_src_a_lreg,
	input wire lreg_t slot0_src_b_lreg,
	input wire lreg_t slot1_src_a_lreg,
	input wire lreg_t slot1_src_b_lreg,
	output preg_t slot0_src_a,
	output preg_t slot0_src_b,
	output preg_t slot0_old,
	output preg_t slot1_src_a,
	output preg_t slot1_src_b,
	output preg_t slot1_old,
	// Physical registers held by some rollback point
	output preg_vec_t rollback_vec
);

	preg_t cur_map [NUM_LREG];
	preg_t rb_map [NUM_LREG];
	// Slot 1 fields that name slot 0's destination
	logic hit_a;
	logic hit_b;
	logic hit_dest;

	for (genvar g = 0; g < NUM_LREG; g++) begin : g_entry
		rename_map_entry #(
			.ENTRY_ID(lreg_t'(g))
		) u_entry (
			.iCLOCK(iCLOCK),
			.inRESET(inRESET),
			.restart(restart),
			.commit0_valid(commit0_valid),
			.commit0_lreg(commit0_lreg),
			.commit0_preg(commit0_preg),
			.commit1_valid(commit1_valid),
			.commit1_lreg(commit1_lreg),
			.commit1_preg(commit1_preg),
			.commit2_valid(commit2_valid),
			.commit2_lreg(commit2_lreg),
			.commit2_preg(commit2_preg),
			.commit3_valid(commit3_valid),
			.commit3_lreg(commit3_lreg),
			.commit3_preg(commit3_preg),
			.lock(lock),
			.write0_valid(write0_valid),
			.write0_lreg(write0_lreg),
			.write0_preg(write0_preg),
			.write1_valid(write1_valid),
			.write1_lreg(write1_lreg),
			.write1_preg(write1_preg),
			.regname(cur_map[g]),
			.rollback_regname(rb_map[g])
		);
	end

	// Slot 0 sees only the map as it stands
	assign slot0_src_a = cur_map[slot0_src_a_lreg];
	assign slot0_src_b = cur_map[slot0_src_b_lreg];
	assign slot0_old = cur_map[write0_lreg];

	// Same-bundle dependency on slot 0's destination
	assign hit_a = write0_valid && (slot1_src_a_lreg == write0_lreg);
	assign hit_b = write0_valid && (slot1_src_b_lreg == write0_lreg);
	assign hit_dest = write0_valid && (write1_lreg == write0_lreg);

	assign slot1_src_a = hit_a ? write0_preg : cur_map[slot1_src_a_lreg];
	assign slot1_src_b = hit_b ? write0_preg : cur_map[slot1_src_b_lreg];
	// Both write one lreg, slot 1 replaces slot 0's new name
	assign slot1_old = hit_dest ? write0_preg : cur_map[write1_lreg];

	// OR of one-hot decodes of all rollback points
	always_comb begin
		rollback_vec = '0;
		for (int i = 0; i < NUM_LREG; i++) begin
			rollback_vec = rollback_vec | (preg_vec_t'(1) << rb_map[i]);
		end
	end

endmodule

`default_nettype wire

//--- src/rename_map_entry.sv
`timescale 1ns/100ps
`default_nettype none

module rename_map_entry
	import rename_pkg::*;
#(
	parameter lreg_t ENTRY_ID = '0
)(
	input wire iCLOCK,
	input wire inRESET,
	// Full recovery from rollback point
	input wire restart,
	// Commit candidates, higher index wins
	input wire commit0_valid,
	input wire lreg_t commit0_lreg,
	input wire preg_t commit0_preg,
	input wire commit1_valid,
	input wire lreg_t commit1_lreg,
	input wire preg_t commit1_preg,
	input wire commit2_valid,
	input wire lreg_t commit2_lreg,
	input wire preg_t commit2_preg,
	input wire commit3_valid,
	input wire lreg_t commit3_lreg,
	input wire preg_t commit3_preg,
	// Low only in an accepting cycle
	input wire lock,
	// Rename writes from both slots
	input wire write0_valid,
	input wire lreg_t write0_lreg,
	input wire preg_t write0_preg,
	input wire write1_valid,
	input wire lreg_t write1_lreg,
	input wire preg_t write1_preg,
	output preg_t regname,
	output preg_t rollback_regname
);

	// Candidates gathered for the priority loop
	logic [COMMIT_WIDTH-1:0] cand_valid;
	lreg_t cand_lreg [COMMIT_WIDTH];
	preg_t cand_preg [COMMIT_WIDTH];

	// Identity mapping loaded yet
	logic loaded;
	// Speculative mapping
	preg_t cur_q;
	// Committed mapping
	preg_t rb_q;
	preg_t rb_next;
	logic wr0_hit;
	logic wr1_hit;

	assign cand_valid = {commit3_valid, commit2_valid, commit1_valid, commit0_valid};
	assign cand_lreg[0] = commit0_lreg;
	assign cand_lreg[1] = commit1_lreg;
	assign cand_lreg[2] = commit2_lreg;
	assign cand_lreg[3] = commit3_lreg;
	assign cand_preg[0] = commit0_preg;
	assign cand_preg[1] = commit1_preg;
	assign cand_preg[2] = commit2_preg;
	assign cand_preg[3] = commit3_preg;

	// Later candidates overwrite earlier ones, so candidate 3 wins
	always_comb begin
		rb_next = rb_q;
		for (int i = 0; i < COMMIT_WIDTH; i++) begin
			if (cand_valid[i] && (cand_lreg[i] == ENTRY_ID)) begin
				rb_next = cand_preg[i];
			end
		end
	end

	assign wr0_hit = write0_valid && (write0_lreg == ENTRY_ID);
	assign wr1_hit = write1_valid && (write1_lreg == ENTRY_ID);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			loaded <= 1'b0;
			cur_q <= '0;
			rb_q <= '0;
		end else if (!loaded) begin
			// Boot with the identity mapping
			loaded <= 1'b1;
			cur_q <= preg_t'(ENTRY_ID);
			rb_q <= preg_t'(ENTRY_ID);
		end else begin
			rb_q <= rb_next;
			// Recovery takes the rollback point as it stood before this edge
			if (restart) begin
				cur_q <= rb_q;
			end else if (!lock) begin
				// Slot 1 is younger, its write is the final one
				if (wr1_hit) begin
					cur_q <= write1_preg;
				end else if (wr0_hit) begin
					cur_q <= write0_preg;
				end
			end
		end
	end

	assign regname = cur_q;
	assign rollback_regname = rb_q;

endmodule

`default_nettype wire

//--- src/rename_pkg.sv
`default_nettype none

package rename_pkg;

	// Architectural and physical register counts
	localparam int NUM_LREG = 32;
	localparam int NUM_PREG = 64;

	// Instructions renamed per cycle
	localparam int RENAME_WIDTH = 2;
	// Commit candidates per cycle from retirement
	localparam int COMMIT_WIDTH = 4;

	// Logical register number
	typedef logic [$clog2(NUM_LREG)-1:0] lreg_t;

	// Physical register number
	typedef logic [$clog2(NUM_PREG)-1:0] preg_t;

	// One bit per physical register
	typedef logic [NUM_PREG-1:0] preg_vec_t;

	// Free list controller, boot load then normal operation
	typedef enum logic {
		init = 1'b0,
		run  = 1'b1
	} free_state_t;

endpackage

`default_nettype wire
